/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_mem_cluster
FILELIST := src.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* design/cluster_pkg.sv */
//////////////////////////////////////////////////
// Shared sizes, address fields and link payloads
// for the four-group memory cluster
//////////////////////////////////////////////////

`default_nettype none

package cluster_pkg;

  // Cluster geometry
  localparam int unsigned num_groups = 4;
  localparam int unsigned group_w    = 2;
  localparam int unsigned bank_words = 16;
  localparam int unsigned offset_w   = 4;

  // Group index sits above the word offset
  localparam int unsigned addr_w = group_w + offset_w;
  localparam int unsigned data_w = 32;
  localparam int unsigned tag_w  = 4;

  // Direction = target group xor own group
  localparam logic [group_w-1:0] dir_local     = 2'd0;
  localparam logic [group_w-1:0] dir_east      = 2'd1;
  localparam logic [group_w-1:0] dir_north     = 2'd2;
  localparam logic [group_w-1:0] dir_northeast = 2'd3;

  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } opcode_e;

  // Request as issued by a core port, 43 bits
  typedef struct packed {
    opcode_e             opcode;
    logic [addr_w-1:0]   addr;
    logic [data_w-1:0]   wdata;
    logic [tag_w-1:0]    tag;
  } core_req_t;

  // Request on its way to a bank, 45 bits
  typedef struct packed {
    core_req_t           req;
    logic [group_w-1:0]  src;
  } link_req_t;

  // Response back to the issuing group, 38 bits
  typedef struct packed {
    logic [data_w-1:0]   rdata;
    logic [tag_w-1:0]    tag;
    logic [group_w-1:0]  dst;
  } resp_t;

endpackage : cluster_pkg

`default_nettype wire

/* design/mem_cluster.sv */
//////////////////////////////////////////////////
// Four-group memory cluster, groups joined by
// east, north and northeast links
//////////////////////////////////////////////////

`default_nettype none

module mem_cluster (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  cluster_pkg::core_req_t [cluster_pkg::num_groups-1:0] core_req_i,
  input  logic                   [cluster_pkg::num_groups-1:0] core_req_valid_i,
  output logic                   [cluster_pkg::num_groups-1:0] core_req_ready_o,
  output cluster_pkg::resp_t     [cluster_pkg::num_groups-1:0] core_resp_o,
  output logic                   [cluster_pkg::num_groups-1:0] core_resp_valid_o,
  input  logic                   [cluster_pkg::num_groups-1:0] core_resp_ready_i
);

  // Per group, per direction minus one
  cluster_pkg::link_req_t [cluster_pkg::num_groups-1:0][2:0] mst_req;
  logic                   [cluster_pkg::num_groups-1:0][2:0] mst_req_valid;
  logic                   [cluster_pkg::num_groups-1:0][2:0] mst_req_ready;
  cluster_pkg::resp_t     [cluster_pkg::num_groups-1:0][2:0] mst_resp;
  logic                   [cluster_pkg::num_groups-1:0][2:0] mst_resp_valid;
  logic                   [cluster_pkg::num_groups-1:0][2:0] mst_resp_ready;
  cluster_pkg::link_req_t [cluster_pkg::num_groups-1:0][2:0] slv_req;
  logic                   [cluster_pkg::num_groups-1:0][2:0] slv_req_valid;
  logic                   [cluster_pkg::num_groups-1:0][2:0] slv_req_ready;
  cluster_pkg::resp_t     [cluster_pkg::num_groups-1:0][2:0] slv_resp;
  logic                   [cluster_pkg::num_groups-1:0][2:0] slv_resp_valid;
  logic                   [cluster_pkg::num_groups-1:0][2:0] slv_resp_ready;

  for (genvar g = 0; g < cluster_pkg::num_groups; g++) begin : gen_groups
    mem_group #(
      .GroupId(g)
    ) i_group (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .core_req_i       (core_req_i[g]),
      .core_req_valid_i (core_req_valid_i[g]),
      .core_req_ready_o (core_req_ready_o[g]),
      .core_resp_o      (core_resp_o[g]),
      .core_resp_valid_o(core_resp_valid_o[g]),
      .core_resp_ready_i(core_resp_ready_i[g]),
      .mst_req_o        (mst_req[g]),
      .mst_req_valid_o  (mst_req_valid[g]),
      .mst_req_ready_i  (mst_req_ready[g]),
      .mst_resp_i       (mst_resp[g]),
      .mst_resp_valid_i (mst_resp_valid[g]),
      .mst_resp_ready_o (mst_resp_ready[g]),
      .slv_req_i        (slv_req[g]),
      .slv_req_valid_i  (slv_req_valid[g]),
      .slv_req_ready_o  (slv_req_ready[g]),
      .slv_resp_o       (slv_resp[g]),
      .slv_resp_valid_o (slv_resp_valid[g]),
      .slv_resp_ready_i (slv_resp_ready[g])
    );
  end : gen_groups

  // Master link d of group g lands on slave link d of group g xor d
  for (genvar g = 0; g < cluster_pkg::num_groups; g++) begin : gen_links
    for (genvar d = 1; d < cluster_pkg::num_groups; d++) begin : gen_dir
      assign slv_req[g ^ d][d-1]        = mst_req[g][d-1];
      assign slv_req_valid[g ^ d][d-1]  = mst_req_valid[g][d-1];
      assign mst_req_ready[g][d-1]      = slv_req_ready[g ^ d][d-1];
      assign mst_resp[g ^ d][d-1]       = slv_resp[g][d-1];
      assign mst_resp_valid[g ^ d][d-1] = slv_resp_valid[g][d-1];
      assign slv_resp_ready[g][d-1]     = mst_resp_ready[g ^ d][d-1];
    end : gen_dir
  end : gen_links

  if (cluster_pkg::num_groups != 4) begin : gen_size_check
    $fatal(1, "mem_cluster: the xor direction wiring needs exactly four groups");
  end

endmodule : mem_cluster

`default_nettype wire

/* design/mem_group.sv */
//////////////////////////////////////////////////
// One cluster group: request routing, bank
// arbitration and response merging
//////////////////////////////////////////////////

`default_nettype none

module mem_group #(
  parameter int unsigned GroupId = 0
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Core port
  input  cluster_pkg::core_req_t       core_req_i,
  input  logic                         core_req_valid_i,
  output logic                         core_req_ready_o,
  output cluster_pkg::resp_t           core_resp_o,
  output logic                         core_resp_valid_o,
  input  logic                         core_resp_ready_i,
  // Outgoing requests, index is direction minus one
  output cluster_pkg::link_req_t [2:0] mst_req_o,
  output logic                   [2:0] mst_req_valid_o,
  input  logic                   [2:0] mst_req_ready_i,
  input  cluster_pkg::resp_t     [2:0] mst_resp_i,
  input  logic                   [2:0] mst_resp_valid_i,
  output logic                   [2:0] mst_resp_ready_o,
  // Incoming requests from the other groups
  input  cluster_pkg::link_req_t [2:0] slv_req_i,
  input  logic                   [2:0] slv_req_valid_i,
  output logic                   [2:0] slv_req_ready_o,
  output cluster_pkg::resp_t     [2:0] slv_resp_o,
  output logic                   [2:0] slv_resp_valid_o,
  input  logic                   [2:0] slv_resp_ready_i
);

  logic [cluster_pkg::group_w-1:0]    own_id;
  logic [cluster_pkg::group_w-1:0]    req_dir;
  logic [cluster_pkg::group_w-1:0]    resp_dir;
  logic [cluster_pkg::num_groups-1:0] req_sel;
  logic [cluster_pkg::num_groups-1:0] resp_sel;
  cluster_pkg::link_req_t             local_req;

  cluster_pkg::link_req_t [cluster_pkg::num_groups-1:0] bank_in;
  logic [cluster_pkg::num_groups-1:0] bank_in_valid;
  logic [cluster_pkg::num_groups-1:0] bank_gnt;
  logic                               bank_idle;
  cluster_pkg::link_req_t             bank_req;
  logic                               bank_req_valid;
  logic                               bank_req_ready;
  cluster_pkg::resp_t                 bank_resp;
  logic                               bank_resp_valid;
  logic                               bank_resp_ready;

  cluster_pkg::resp_t [cluster_pkg::num_groups-1:0] merge_in;
  logic [cluster_pkg::num_groups-1:0] merge_in_valid;
  logic [cluster_pkg::num_groups-1:0] merge_gnt;

  assign own_id    = GroupId[cluster_pkg::group_w-1:0];
  assign req_dir   = core_req_i.addr[cluster_pkg::addr_w-1:cluster_pkg::offset_w] ^ own_id;
  assign resp_dir  = bank_resp.dst ^ own_id;
  assign req_sel   = {{(cluster_pkg::num_groups - 1){1'b0}}, 1'b1} << req_dir;
  assign resp_sel  = {{(cluster_pkg::num_groups - 1){1'b0}}, 1'b1} << resp_dir;
  assign local_req = '{req: core_req_i, src: own_id};

  // Ports look ready while the bank arbiter has nothing granted
  assign bank_idle = ~|bank_gnt;

  // Requester 0 is the own core, 1 to 3 the remote directions
  assign bank_in[0]        = local_req;
  assign bank_in_valid[0]  = core_req_valid_i && req_sel[0];
  assign merge_in[0]       = bank_resp;
  assign merge_in_valid[0] = bank_resp_valid && resp_sel[0];

  for (genvar d = 1; d < cluster_pkg::num_groups; d++) begin : gen_dir
    assign mst_req_o[d-1]       = local_req;
    assign mst_req_valid_o[d-1] = core_req_valid_i && req_sel[d];
    assign bank_in[d]           = slv_req_i[d-1];
    assign bank_in_valid[d]     = slv_req_valid_i[d-1];
    assign slv_req_ready_o[d-1] = (bank_gnt[d] || bank_idle) && bank_req_ready;

    assign slv_resp_o[d-1]       = bank_resp;
    assign slv_resp_valid_o[d-1] = bank_resp_valid && resp_sel[d];
    assign merge_in[d]           = mst_resp_i[d-1];
    assign merge_in_valid[d]     = mst_resp_valid_i[d-1];
    assign mst_resp_ready_o[d-1] = merge_gnt[d] && core_resp_ready_i;
  end : gen_dir

  always_comb begin
    unique case (req_dir)
      cluster_pkg::dir_local:     core_req_ready_o = (bank_gnt[0] || bank_idle) && bank_req_ready;
      cluster_pkg::dir_east:      core_req_ready_o = mst_req_ready_i[0];
      cluster_pkg::dir_north:     core_req_ready_o = mst_req_ready_i[1];
      cluster_pkg::dir_northeast: core_req_ready_o = mst_req_ready_i[2];
    endcase
  end

  always_comb begin
    unique case (resp_dir)
      cluster_pkg::dir_local:     bank_resp_ready = merge_gnt[0] && core_resp_ready_i;
      cluster_pkg::dir_east:      bank_resp_ready = slv_resp_ready_i[0];
      cluster_pkg::dir_north:     bank_resp_ready = slv_resp_ready_i[1];
      cluster_pkg::dir_northeast: bank_resp_ready = slv_resp_ready_i[2];
    endcase
  end

  // Grant muxes
  always_comb begin
    bank_req    = bank_in[0];
    core_resp_o = merge_in[0];
    for (int i = 1; i < cluster_pkg::num_groups; i++) begin
      if (bank_gnt[i]) begin
        bank_req = bank_in[i];
      end
      if (merge_gnt[i]) begin
        core_resp_o = merge_in[i];
      end
    end
  end

  assign bank_req_valid    = |bank_gnt;
  assign core_resp_valid_o = |merge_gnt;

  rr_arbiter i_bank_arb (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (bank_in_valid),
    .ack_i   (bank_req_valid && bank_req_ready),
    .gnt_o   (bank_gnt)
  );

  tcdm_bank i_bank (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (bank_req),
    .req_valid_i (bank_req_valid),
    .req_ready_o (bank_req_ready),
    .resp_o      (bank_resp),
    .resp_valid_o(bank_resp_valid),
    .resp_ready_i(bank_resp_ready)
  );

  rr_arbiter i_resp_arb (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (merge_in_valid),
    .ack_i   (core_resp_valid_o && core_resp_ready_i),
    .gnt_o   (merge_gnt)
  );

endmodule : mem_group

`default_nettype wire

/* design/rr_arbiter.sv */
//////////////////////////////////////////////////
// Four-way round-robin arbiter, grant held
// until the chosen request has been taken
//////////////////////////////////////////////////

`default_nettype none

module rr_arbiter (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [cluster_pkg::num_groups-1:0] req_i,
  input  logic                              ack_i,
  output logic [cluster_pkg::num_groups-1:0] gnt_o
);

  logic [cluster_pkg::group_w-1:0] ptr_q;
  logic [cluster_pkg::group_w-1:0] win_q;
  logic [cluster_pkg::group_w-1:0] win;
  logic [cluster_pkg::group_w-1:0] search_win;
  logic                            lock_q;
  logic                            any;

  // First request at or after the pointer
  always_comb begin
    logic [cluster_pkg::group_w-1:0] idx;
    search_win = ptr_q;
    for (int i = cluster_pkg::num_groups - 1; i >= 0; i--) begin
      idx = ptr_q + i[cluster_pkg::group_w-1:0];
      if (req_i[idx]) begin
        search_win = idx;
      end
    end
  end

  // A stalled grant is frozen so the payload downstream stays put
  assign win = lock_q ? win_q : search_win;
  assign any = lock_q || (|req_i);

  always_comb begin
    gnt_o = '0;
    if (any) begin
      gnt_o[win] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q  <= '0;
      win_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= any && !ack_i;
      if (any) begin
        win_q <= win;
      end
      if (any && ack_i) begin
        ptr_q <= win + 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(gnt_o));

endmodule : rr_arbiter

`default_nettype wire

/* design/tcdm_bank.sv */
//////////////////////////////////////////////////
// Single-port word bank with registered response
//////////////////////////////////////////////////

`default_nettype none

module tcdm_bank (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  cluster_pkg::link_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output cluster_pkg::resp_t     resp_o,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i
);

  logic [cluster_pkg::data_w-1:0]   mem [cluster_pkg::bank_words];
  logic [cluster_pkg::offset_w-1:0] offset;
  logic                             accept;
  cluster_pkg::resp_t               resp_q;
  logic                             resp_valid_q;

  assign offset = req_i.req.addr[cluster_pkg::offset_w-1:0];

  // Free slot if nothing is pending or the pending one leaves now
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_i.req.opcode == cluster_pkg::op_write) begin
        mem[offset]  <= req_i.req.wdata;
        resp_q.rdata <= req_i.req.wdata;
      end else begin
        resp_q.rdata <= mem[offset];
      end
      resp_q.tag <= req_i.req.tag;
      resp_q.dst <= req_i.src;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule : tcdm_bank

`default_nettype wire

/* src.f */
design/cluster_pkg.sv
design/rr_arbiter.sv
design/tcdm_bank.sv
design/mem_group.sv
design/mem_cluster.sv
test/tb_mem_cluster.sv

/* test/tb_mem_cluster.sv */
//////////////////////////////////////////////////
// Table-driven testbench for the memory cluster
// with a reference memory and random back-pressure
//////////////////////////////////////////////////

`default_nettype none

module tb_mem_cluster;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int phase_timeout = 300;
  localparam int num_phases    = 5;

  typedef struct packed {
    logic [1:0]            grp;
    cluster_pkg::opcode_e  op;
    logic [5:0]            addr;
    logic [31:0]           wdata;
    logic [2:0]            phase;
    logic [3:0]            tag;
  } entry_t;

  logic                          clk_i;
  logic                          arst_n_i;
  cluster_pkg::core_req_t [3:0]  core_req_i;
  logic                   [3:0]  core_req_valid_i;
  logic                   [3:0]  core_req_ready_o;
  cluster_pkg::resp_t     [3:0]  core_resp_o;
  logic                   [3:0]  core_resp_valid_o;
  logic                   [3:0]  core_resp_ready_i;

  entry_t      table_q[$];
  logic [3:0]  next_tag;
  logic [31:0] lfsr_q;
  logic [31:0] ref_mem [64];
  bit          outst [16];
  logic [1:0]  exp_grp [16];
  logic [31:0] exp_data [16];
  int          outstanding;
  int          n_checks;
  int          n_errors;
  bit          timed_out;

  mem_cluster DUT (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .core_req_i       (core_req_i),
    .core_req_valid_i (core_req_valid_i),
    .core_req_ready_o (core_req_ready_o),
    .core_resp_o      (core_resp_o),
    .core_resp_valid_o(core_resp_valid_o),
    .core_resp_ready_i(core_resp_ready_i)
  );

  always #2 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_entry(input int g, input cluster_pkg::opcode_e op, input logic [5:0] addr,
                           input int p);
    entry_t e;
    e.grp   = g[1:0];
    e.op    = op;
    e.addr  = addr;
    e.wdata = (op == cluster_pkg::op_write) ? lfsr_bits(32) : 32'h0;
    e.phase = p[2:0];
    e.tag   = next_tag;
    next_tag++;
    table_q.push_back(e);
  endtask

  function automatic int find_next(input int g, input int p, input int start);
    for (int i = start; i < table_q.size(); i++) begin
      if (int'(table_q[i].grp) == g && int'(table_q[i].phase) == p) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic drive_port(input int g, input int idx);
    if (idx < 0) begin
      core_req_valid_i[g] = 1'b0;
      core_req_i[g]       = '0;
    end else begin
      core_req_i[g] = '{opcode: table_q[idx].op, addr: table_q[idx].addr,
                        wdata: table_q[idx].wdata, tag: table_q[idx].tag};
      core_req_valid_i[g] = 1'b1;
    end
  endtask

  // Prediction at the accepting edge follows the bank's own order
  task automatic predict(input int g, input int idx);
    entry_t      e;
    logic [31:0] exp;
    e = table_q[idx];
    if (e.op == cluster_pkg::op_write) begin
      ref_mem[e.addr] = e.wdata;
      exp = e.wdata;
    end else begin
      exp = ref_mem[e.addr];
    end
    outst[e.tag]    = 1'b1;
    exp_grp[e.tag]  = g[1:0];
    exp_data[e.tag] = exp;
    outstanding++;
  endtask

  task automatic take_response(input int g);
    logic [3:0] t;
    t = core_resp_o[g].tag;
    if (!outst[t] || int'(exp_grp[t]) != g) begin
      n_errors++;
      $display("error at %0t: unexpected or duplicate response with tag %0d on group %0d",
               $time, t, g);
    end else begin
      check_value($sformatf("core_resp_o[%0d].rdata", g), 64'(core_resp_o[g].rdata),
                  64'(exp_data[t]));
      check_value($sformatf("core_resp_o[%0d].dst", g), 64'(core_resp_o[g].dst), 64'(g));
      outst[t] = 1'b0;
      outstanding--;
    end
  endtask

  task automatic run_phase(input int p, output bit timeout_hit);
    int                 cur [4];
    bit                 fired [4];
    bit                 held_v [4];
    cluster_pkg::resp_t held [4];
    logic [31:0]        rnd;
    int                 cycles;
    bit                 busy;
    timeout_hit = 1'b0;
    cycles      = 0;
    busy        = 1'b1;
    @(posedge clk_i);
    #1;
    for (int g = 0; g < 4; g++) begin
      cur[g]    = find_next(g, p, 0);
      held_v[g] = 1'b0;
      drive_port(g, cur[g]);
    end
    while (busy && !timeout_hit) begin
      @(negedge clk_i);
      for (int g = 0; g < 4; g++) begin
        fired[g] = core_req_valid_i[g] && core_req_ready_o[g];
        if (fired[g]) begin
          predict(g, cur[g]);
        end
        // A stalled response must hold until taken
        if (held_v[g]) begin
          check_value($sformatf("core_resp_valid_o[%0d]", g), 64'(core_resp_valid_o[g]), 64'd1);
          check_value($sformatf("core_resp_o[%0d]", g), 64'(core_resp_o[g]), 64'(held[g]));
        end
        if (core_resp_valid_o[g] && core_resp_ready_i[g]) begin
          take_response(g);
        end
        held_v[g] = core_resp_valid_o[g] && !core_resp_ready_i[g];
        held[g]   = core_resp_o[g];
      end
      @(posedge clk_i);
      #1;
      busy = outstanding > 0;
      for (int g = 0; g < 4; g++) begin
        if (fired[g]) begin
          cur[g] = find_next(g, p, cur[g] + 1);
          drive_port(g, cur[g]);
        end
        busy = busy || cur[g] >= 0;
      end
      rnd = (p == 4) ? lfsr_bits(4) : 32'hf;
      core_resp_ready_i = rnd[3:0];
      cycles++;
      if (busy && cycles > phase_timeout) begin
        timeout_hit = 1'b1;
        $display("timeout in phase %0d with %0d responses outstanding", p, outstanding);
      end
    end
  endtask

  task automatic build_table();
    logic [31:0] r;
    logic [3:0]  offs [4];
    offs = '{4'h1, 4'h5, 4'h6, 4'h9};
    // Phase 0 local write and read back, phases 1 and 2 every remote direction
    for (int g = 0; g < 4; g++) begin
      add_entry(g, cluster_pkg::op_write, {g[1:0], 4'h1}, 0);
      add_entry(g, cluster_pkg::op_write, {g[1:0], 4'h9}, 0);
      add_entry(g, cluster_pkg::op_read, {g[1:0], 4'h1}, 0);
      add_entry(g, cluster_pkg::op_read, {g[1:0], 4'h9}, 0);
    end
    for (int g = 0; g < 4; g++) begin
      for (int d = 1; d < 4; d++) begin
        add_entry(g, cluster_pkg::op_write, {g[1:0] ^ d[1:0], 4'h4 + d[3:0]}, 1);
      end
    end
    for (int g = 0; g < 4; g++) begin
      for (int d = 1; d < 4; d++) begin
        add_entry(g, cluster_pkg::op_read, {g[1:0] ^ d[1:0], 4'h4 + d[3:0]}, 2);
      end
    end
    // All groups hit bank 2 in the same cycle
    for (int g = 0; g < 4; g++) begin
      add_entry(g, cluster_pkg::op_write, {2'd2, 4'hc + g[3:0]}, 3);
      add_entry(g, cluster_pkg::op_read, {2'd2, 4'hc + g[3:0]}, 3);
    end
    // Mixed traffic on words already written
    for (int i = 0; i < 16; i++) begin
      r = lfsr_bits(7);
      add_entry(int'(r[6:5]), cluster_pkg::opcode_e'(r[4]), {r[3:2], offs[r[1:0]]}, 4);
    end
  endtask

  initial begin
    clk_i             = 1'b0;
    arst_n_i          = 1'b0;
    core_req_i        = '0;
    core_req_valid_i  = '0;
    core_resp_ready_i = '1;
    lfsr_q            = 32'hfbc6fdd8;
    next_tag          = '0;
    outstanding       = 0;
    n_checks          = 0;
    n_errors          = 0;
    timed_out         = 1'b0;
    for (int i = 0; i < 16; i++) begin
      outst[i] = 1'b0;
    end
    build_table();
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    // Idle ports show no response and are all ready
    @(negedge clk_i);
    check_value("core_resp_valid_o", 64'(core_resp_valid_o), 64'h0);
    check_value("core_req_ready_o", 64'(core_req_ready_o), 64'hf);
    for (int p = 0; p < num_phases; p++) begin
      if (!timed_out) begin
        run_phase(p, timed_out);
      end
    end
    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, int'(timed_out));
    if (timed_out || n_errors != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule : tb_mem_cluster

`default_nettype wire
